/* design/core_define.svh */
`ifndef CORE_DEFINE_SVH
`define CORE_DEFINE_SVH

// Descending bit range for a field of width w
`define WDEF(w) ((w)-1):0

`endif

/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Reorder buffer index width
    localparam int ROB_IDX_W = 6;

    // Plain unsigned age tag, larger means younger
    typedef logic [ROB_IDX_W-1:0] robIdx_t;

endpackage

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;
    import core_pkg::*;

    localparam int SQ_DEPTH = 8;
    localparam int SQ_PTR_W = $clog2(SQ_DEPTH);
    localparam int SQ_CNT_W = SQ_PTR_W + 1;         // Counts 0 to SQ_DEPTH
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    typedef enum logic {
        SQ_FREE  = 1'b0,
        SQ_VALID = 1'b1
    } sq_state_e;

    // Store write into the queue
    typedef struct packed {
        robIdx_t rob_idx;
        addr_t   addr;
        data_t   data;
    } st_req_t;

    // Load search request
    typedef struct packed {
        logic    vld;
        robIdx_t rob_idx;
        addr_t   addr;
    } ld_req_t;

    typedef struct packed {
        logic    vld;
        logic    hit;
        robIdx_t rob_idx;                            // Index of the forwarding store
        data_t   data;
    } fwd_rsp_t;

    typedef struct packed {
        logic    vld;
        robIdx_t rob_idx;
        addr_t   addr;
        data_t   data;
    } sq_entry_t;

endpackage

`default_nettype wire

/* design/newest_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_define.svh"

module newest_select
    import core_pkg::*;
#(
    parameter int  WIDTH = 4,
    parameter type dtype = logic [3:0]
) (
    input  wire [`WDEF(WIDTH)] i_vld,
    input  wire robIdx_t       i_rob_idx[WIDTH],
    input  wire dtype          i_datas[WIDTH],
    output robIdx_t            o_newest_rob_idx,
    output dtype               o_newest_data
);

    // Lower half takes the odd element
    localparam int LO_LEN = (WIDTH + 1) / 2;
    localparam int HI_LEN = WIDTH - LO_LEN;

    generate
        if (WIDTH == 1) begin : gen_leaf
            assign o_newest_rob_idx = i_vld[0] ? i_rob_idx[0] : '0;  // Zero when nothing valid
            assign o_newest_data    = i_vld[0] ? i_datas[0] : '0;
        end else begin : gen_split
            robIdx_t lo_rob_idx;
            robIdx_t hi_rob_idx;
            dtype    lo_data;
            dtype    hi_data;
            logic    lo_vld;
            logic    hi_vld;
            logic    pick_hi;

            newest_select #(
                .WIDTH(LO_LEN),
                .dtype(dtype)
            ) u_newest_select_lo (
                .i_vld           (i_vld[LO_LEN-1:0]),
                .i_rob_idx       (i_rob_idx[0:LO_LEN-1]),
                .i_datas         (i_datas[0:LO_LEN-1]),
                .o_newest_rob_idx(lo_rob_idx),
                .o_newest_data   (lo_data)
            );

            newest_select #(
                .WIDTH(HI_LEN),
                .dtype(dtype)
            ) u_newest_select_hi (
                .i_vld           (i_vld[WIDTH-1:LO_LEN]),
                .i_rob_idx       (i_rob_idx[LO_LEN:WIDTH-1]),
                .i_datas         (i_datas[LO_LEN:WIDTH-1]),
                .o_newest_rob_idx(hi_rob_idx),
                .o_newest_data   (hi_data)
            );

            assign lo_vld = |i_vld[LO_LEN-1:0];
            assign hi_vld = |i_vld[WIDTH-1:LO_LEN];

            // Upper winner only if it alone is valid or is younger
            assign pick_hi = hi_vld & (~lo_vld | (hi_rob_idx > lo_rob_idx));

            assign o_newest_rob_idx = pick_hi ? hi_rob_idx : lo_rob_idx;
            assign o_newest_data    = pick_hi ? hi_data : lo_data;
        end
    endgenerate

endmodule

`default_nettype wire

/* design/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue
    import lsu_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_arst_n,
    input  wire          i_st_wr,
    input  wire st_req_t i_st_req,
    input  wire          i_st_retire,
    input  wire          i_flush,
    output sq_entry_t    o_entries[SQ_DEPTH],
    output logic         o_sq_full,
    output logic         o_sq_empty
);

    logic [SQ_PTR_W-1:0] head_q;                     // Oldest entry
    logic [SQ_PTR_W-1:0] tail_q;                     // Next free slot
    logic [SQ_CNT_W-1:0] count_q;
    sq_state_e           state_q[SQ_DEPTH];
    st_req_t             mem_q[SQ_DEPTH];
    logic                do_wr;
    logic                do_ret;

    assign o_sq_full  = (count_q == SQ_CNT_W'(SQ_DEPTH));
    assign o_sq_empty = (count_q == '0);

    // Flush overrides both write and retire
    assign do_wr  = i_st_wr & ~o_sq_full & ~i_flush;
    assign do_ret = i_st_retire & ~o_sq_empty & ~i_flush;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (i_flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_wr) begin
                tail_q <= tail_q + 1'b1;             // Wraps at SQ_DEPTH
            end
            if (do_ret) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_wr, do_ret})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;         // Both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                state_q[i] <= SQ_FREE;
            end
        end else if (i_flush) begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                state_q[i] <= SQ_FREE;
            end
        end else begin
            if (do_ret) begin
                state_q[head_q] <= SQ_FREE;
            end
            if (do_wr) begin
                state_q[tail_q] <= SQ_VALID;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem_q[tail_q] <= i_st_req;
        end
    end

    // Registered contents only, so a search sees the pre-update queue
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            o_entries[i].vld     = (state_q[i] == SQ_VALID);
            o_entries[i].rob_idx = mem_q[i].rob_idx;
            o_entries[i].addr    = mem_q[i].addr;
            o_entries[i].data    = mem_q[i].data;
        end
    end

endmodule

`default_nettype wire

/* design/store_forward.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_define.svh"

module store_forward
    import core_pkg::*;
    import lsu_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_arst_n,
    input  wire ld_req_t   i_ld_req,
    input  wire sq_entry_t i_entries[SQ_DEPTH],
    output fwd_rsp_t       o_fwd_rsp
);

    logic [`WDEF(SQ_DEPTH)] match;
    robIdx_t                ent_rob_idx[SQ_DEPTH];
    data_t                  ent_data[SQ_DEPTH];
    robIdx_t                sel_rob_idx;
    data_t                  sel_data;
    logic                   rsp_vld_q;
    logic                   rsp_hit_q;
    robIdx_t                rsp_rob_idx_q;
    data_t                  rsp_data_q;

    // Valid, same word and strictly older than the load
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            match[i]       = i_entries[i].vld
                           && (i_entries[i].addr == i_ld_req.addr)
                           && (i_entries[i].rob_idx < i_ld_req.rob_idx);
            ent_rob_idx[i] = i_entries[i].rob_idx;
            ent_data[i]    = i_entries[i].data;
        end
    end

    newest_select #(
        .WIDTH(SQ_DEPTH),
        .dtype(data_t)
    ) u_newest_select (
        .i_vld           (match),
        .i_rob_idx       (ent_rob_idx),
        .i_datas         (ent_data),
        .o_newest_rob_idx(sel_rob_idx),
        .o_newest_data   (sel_data)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rsp_vld_q <= 1'b0;
            rsp_hit_q <= 1'b0;
        end else begin
            rsp_vld_q <= i_ld_req.vld;
            rsp_hit_q <= i_ld_req.vld & (|match);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ld_req.vld) begin
            rsp_rob_idx_q <= sel_rob_idx;            // Zero on a miss
            rsp_data_q    <= sel_data;
        end
    end

    assign o_fwd_rsp = '{
        vld:     rsp_vld_q,
        hit:     rsp_hit_q,
        rob_idx: rsp_rob_idx_q,
        data:    rsp_data_q
    };

endmodule

`default_nettype wire

/* design/sq_forward_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_forward_top
    import lsu_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_arst_n,

    input  wire          i_st_wr,
    input  wire st_req_t i_st_req,
    input  wire          i_st_retire,
    input  wire          i_flush,

    input  wire ld_req_t i_ld_req,
    output fwd_rsp_t     o_fwd_rsp,

    output logic         o_sq_full,
    output logic         o_sq_empty
);

    sq_entry_t entries[SQ_DEPTH];                    // Queue snapshot to the search

    store_queue u_store_queue (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_st_wr    (i_st_wr),
        .i_st_req   (i_st_req),
        .i_st_retire(i_st_retire),
        .i_flush    (i_flush),
        .o_entries  (entries),
        .o_sq_full  (o_sq_full),
        .o_sq_empty (o_sq_empty)
    );

    store_forward u_store_forward (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_ld_req (i_ld_req),
        .i_entries(entries),
        .o_fwd_rsp(o_fwd_rsp)
    );

endmodule

`default_nettype wire

/* testbench/sq_forward_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_forward_asserts
    import lsu_pkg::*;
(
    input wire           i_clk,
    input wire           i_arst_n,
    input wire           i_st_wr,
    input wire ld_req_t  i_ld_req,
    input wire fwd_rsp_t o_fwd_rsp,
    input wire           o_sq_full,
    input wire           o_sq_empty
);

    a_no_wr_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_sq_full |-> !i_st_wr)
        else $error("store write issued while queue full");

    // Every request gets a response on the next cycle
    a_rsp_follows_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ld_req.vld |=> o_fwd_rsp.vld)
        else $error("no response one cycle after load request");

    a_hit_has_vld: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_fwd_rsp.hit |-> o_fwd_rsp.vld)
        else $error("hit without valid response");

    a_full_empty_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_sq_full && o_sq_empty))
        else $error("queue full and empty at once");

    a_rsp_idle_after_rst: assert property (@(posedge i_clk)
        $rose(i_arst_n) |-> (!o_fwd_rsp.vld && !o_fwd_rsp.hit))
        else $error("response active when leaving reset");

endmodule

bind sq_forward_top sq_forward_asserts u_sq_forward_asserts (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_st_wr   (i_st_wr),
    .i_ld_req  (i_ld_req),
    .o_fwd_rsp (o_fwd_rsp),
    .o_sq_full (o_sq_full),
    .o_sq_empty(o_sq_empty)
);

`default_nettype wire

/* testbench/tb_sq_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sq_forward
    import core_pkg::*;
    import lsu_pkg::*;
();

    typedef struct packed {
        fwd_rsp_t rsp;
        logic     full;
        logic     empty;
    } exp_t;

    logic     clk;
    logic     arst_n;
    logic     st_wr;
    st_req_t  st_req;
    logic     st_retire;
    logic     flush;
    ld_req_t  ld_req;
    fwd_rsp_t fwd_rsp;
    logic     sq_full;
    logic     sq_empty;

    st_req_t  model_q[$];                            // Oldest store at the front
    exp_t     exp_q[$];
    exp_t     cmp_cur;
    int       next_rob;
    int       issued_count;
    int       checked_count;
    int       check_count;
    int       err_count;
    int       timeout_count;
    integer   seed;

    sq_forward_top dut (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_st_wr    (st_wr),
        .i_st_req   (st_req),
        .i_st_retire(st_retire),
        .i_flush    (flush),
        .i_ld_req   (ld_req),
        .o_fwd_rsp  (fwd_rsp),
        .o_sq_full  (sq_full),
        .o_sq_empty (sq_empty)
    );

    always #2 clk = ~clk;

    // Youngest same-address store that is older than the load
    function automatic fwd_rsp_t ref_fwd(input ld_req_t ld);
        fwd_rsp_t r;
        r     = '0;
        r.vld = ld.vld;
        if (ld.vld) begin
            foreach (model_q[i]) begin
                if (model_q[i].addr == ld.addr && model_q[i].rob_idx < ld.rob_idx &&
                    (!r.hit || model_q[i].rob_idx > r.rob_idx)) begin
                    r.hit     = 1'b1;
                    r.rob_idx = model_q[i].rob_idx;
                    r.data    = model_q[i].data;
                end
            end
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected,
                     actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    // One clock of stimulus; the model sees the queue as it was before this cycle
    task automatic step_cycle(input logic wr, input st_req_t sreq, input logic ret,
                              input logic fl, input ld_req_t lreq);
        exp_t e;
        logic was_full;
        @(posedge clk);
        #0.5;
        st_wr     = wr;
        st_req    = sreq;
        st_retire = ret;
        flush     = fl;
        ld_req    = lreq;
        e.rsp     = ref_fwd(lreq);
        was_full  = (model_q.size() == SQ_DEPTH);
        if (fl) begin
            model_q.delete();
        end else begin
            if (ret && model_q.size() > 0) begin
                model_q.delete(0);
            end
            if (wr && !was_full) begin
                model_q.push_back(sreq);
            end
        end
        e.full  = (model_q.size() == SQ_DEPTH);
        e.empty = (model_q.size() == 0);
        exp_q.push_back(e);
        issued_count++;
    endtask

    task automatic idle_cycle();
        step_cycle(1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic store_word(input addr_t addr, input data_t data);
        st_req_t s;
        s.rob_idx = robIdx_t'(next_rob);
        s.addr    = addr;
        s.data    = data;
        next_rob++;
        step_cycle(1'b1, s, 1'b0, 1'b0, '0);
    endtask

    task automatic load_word(input robIdx_t rob, input addr_t addr);
        ld_req_t l;
        l.vld     = 1'b1;
        l.rob_idx = rob;
        l.addr    = addr;
        step_cycle(1'b0, '0, 1'b0, 1'b0, l);
    endtask

    // Expectation pushed in cycle k is checked after the edge that ends it
    always begin
        @(posedge clk);
        if (exp_q.size() > 0) begin
            cmp_cur = exp_q.pop_front();
            @(negedge clk);
            check_val("o_fwd_rsp.vld", 64'(cmp_cur.rsp.vld), 64'(fwd_rsp.vld));
            check_val("o_fwd_rsp.hit", 64'(cmp_cur.rsp.hit), 64'(fwd_rsp.hit));
            if (cmp_cur.rsp.hit) begin
                check_val("o_fwd_rsp.rob_idx", 64'(cmp_cur.rsp.rob_idx), 64'(fwd_rsp.rob_idx));
                check_val("o_fwd_rsp.data", 64'(cmp_cur.rsp.data), 64'(fwd_rsp.data));
            end
            check_val("o_sq_full", 64'(cmp_cur.full), 64'(sq_full));
            check_val("o_sq_empty", 64'(cmp_cur.empty), 64'(sq_empty));
            checked_count++;
        end
    end

    initial begin
        int          n;
        int          lr;
        logic [31:0] rnd;
        logic        wr;
        logic        ret;
        logic        fl;
        st_req_t     sreq;
        ld_req_t     lreq;

        clk           = 1'b0;
        arst_n        = 1'b0;
        st_wr         = 1'b0;
        st_req        = '0;
        st_retire     = 1'b0;
        flush         = 1'b0;
        ld_req        = '0;
        seed          = 32'ha42c_ff8f;
        next_rob      = 1;
        issued_count  = 0;
        checked_count = 0;
        check_count   = 0;
        err_count     = 0;
        timeout_count = 0;

        repeat (8) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        idle_cycle();

        // Misses on an empty queue and on another address
        load_word(6'd5, 32'h0000_0040);
        store_word(32'h0000_0100, 32'h1111_0001);   // rob 1
        load_word(6'd9, 32'h0000_0104);

        // Several older stores to one word, newest older one wins
        store_word(32'h0000_0200, 32'haaaa_0002);   // rob 2
        store_word(32'h0000_0300, 32'h3333_0003);   // rob 3
        store_word(32'h0000_0200, 32'hbbbb_0004);   // rob 4
        store_word(32'h0000_0200, 32'hcccc_0005);   // rob 5
        load_word(6'd5, 32'h0000_0200);
        load_word(6'd9, 32'h0000_0200);
        load_word(6'd3, 32'h0000_0200);

        // Younger or other-address stores as newest entries
        store_word(32'h0000_0200, 32'hdddd_0006);   // rob 6
        store_word(32'h0000_0204, 32'heeee_0007);   // rob 7
        load_word(6'd6, 32'h0000_0200);
        load_word(6'd9, 32'h0000_0200);

        // Retire in order, then the next-older match forwards
        load_word(6'd4, 32'h0000_0200);
        step_cycle(1'b0, '0, 1'b1, 1'b0, '0);
        step_cycle(1'b0, '0, 1'b1, 1'b0, '0);
        load_word(6'd3, 32'h0000_0200);
        load_word(6'd5, 32'h0000_0200);

        n = 0;
        while (model_q.size() < SQ_DEPTH && n < 2 * SQ_DEPTH) begin
            store_word(32'h0000_0400 + 32'(n * 4), 32'h5000_0000 + 32'(n));
            n++;
        end
        n = 0;
        while (sq_full !== 1'b1 && n < 8) begin
            idle_cycle();
            n++;
        end
        if (sq_full !== 1'b1) begin
            report_timeout("o_sq_full to rise");
        end
        step_cycle(1'b0, '0, 1'b1, 1'b0, '0);
        n = 0;
        while (sq_full !== 1'b0 && n < 8) begin
            idle_cycle();
            n++;
        end
        if (sq_full !== 1'b0) begin
            report_timeout("o_sq_full to fall after retire");
        end

        // Flush empties the queue
        step_cycle(1'b0, '0, 1'b0, 1'b1, '0);
        next_rob = 1;
        n = 0;
        while (sq_empty !== 1'b1 && n < 8) begin
            idle_cycle();
            n++;
        end
        if (sq_empty !== 1'b1) begin
            report_timeout("o_sq_empty after flush");
        end
        load_word(6'd63, 32'h0000_0200);

        // Mixed traffic with a load every cycle
        for (int c = 0; c < 300; c++) begin
            rnd          = $random(seed);
            fl           = (next_rob >= 58) || (rnd[5:0] == 6'd0);
            wr           = !fl && rnd[6] && (model_q.size() < SQ_DEPTH);
            ret          = (rnd[8:7] == 2'b00);
            sreq.rob_idx = robIdx_t'(next_rob);
            sreq.addr    = 32'h0000_1000 + {28'd0, rnd[10:9], 2'b00};
            sreq.data    = $random(seed);
            lr           = int'(rnd[20:13]) % (next_rob + 1) + 1;
            lreq.vld     = 1'b1;
            lreq.rob_idx = robIdx_t'(lr);
            lreq.addr    = 32'h0000_1000 + {28'd0, rnd[12:11], 2'b00};
            step_cycle(wr, sreq, ret, fl, lreq);
            if (wr) begin
                next_rob++;
            end
            if (fl) begin
                next_rob = 1;
            end
        end
        idle_cycle();

        n = 0;
        while (checked_count < issued_count && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (checked_count < issued_count) begin
            report_timeout("outstanding responses to be checked");
        end

        $display("Checks: %0d  errors: %0d  timeouts: %0d", check_count, err_count,
                 timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/core_pkg.sv
design/lsu_pkg.sv
design/newest_select.sv
design/store_queue.sv
design/store_forward.sv
design/sq_forward_top.sv
testbench/sq_forward_asserts.sv
testbench/tb_sq_forward.sv

/* Makefile */
# Verilator flow for the store-queue forwarding testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module tb_sq_forward \
		-Mdir $(OBJ_DIR) -o sim_tb

run: compile
	./$(OBJ_DIR)/sim_tb | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
